// File: vlog.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
inst_decoder.sv
reg_file.sv
exec_stage.sv
alu_core.sv
alu_core_properties.sv
tb_alu_core.sv

// File: Bender.yml
package:
  name: alu_core

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - rv_pipe_pkg.sv
      - inst_decoder.sv
      - reg_file.sv
      - exec_stage.sv
      - alu_core.sv

  - target: test
    include_dirs:
      - .
    files:
      - alu_core_properties.sv
      - tb_alu_core.sv

// File: tb_alu_core.sv
`include "core_config.svh"

module tb_alu_core;

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DLY       = 10;
    localparam int RST_CYCLES      = 16;
    localparam int N_RANDOM        = 400;
    localparam int MAX_GAP         = 3;
    localparam int DIRECTED_CYCLES = 120;
    localparam int TIMEOUT = (RST_CYCLES + DIRECTED_CYCLES + N_RANDOM * (MAX_GAP + 1) + 50)
                             * CLK_PERIOD;

    logic                   clk;
    logic                   rst;
    logic                   inst_valid_i;
    rv_isa_pkg::inst_word_t inst_i;
    logic                   retire_valid_o;
    rv_pipe_pkg::retire_t   retire_o;
    integer                 seed = 32'hb0f5a6c2;

    alu_core u_dut (
        .clk            (clk),
        .rst            (rst),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

    bind alu_core alu_core_properties u_props (
        .clk            (clk),
        .rst            (rst),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .retire_valid_i (retire_valid_o),
        .retire_i       (retire_o)
    );

    // --------------------
    // instruction encoding

    function automatic rv_isa_pkg::inst_word_t make_r(input logic [6:0] f7,
            input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
            input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic rv_isa_pkg::inst_word_t make_i(input logic [2:0] f3,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic rv_isa_pkg::inst_word_t make_lui(input logic [19:0] imm,
            input logic [4:0] rd);
        return {imm, rd, rv_isa_pkg::OPC_LUI};
    endfunction

    // one strobe, then idle cycles
    task automatic send(input rv_isa_pkg::inst_word_t w, input int gap);
        inst_valid_i = 1'b1;
        inst_i = w;
        @(posedge clk);
        #DRIVE_DLY;
        inst_valid_i = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #TIMEOUT;
        $display("tests failed");
        $fatal(1, "watchdog expired before the stimulus finished");
    end

    initial begin
        wait (u_dut.u_props.error_count != 0);
        $display("tests failed");
        $fatal(1, "an assertion on the core's retirements failed");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        rst = 1'b1;
        inst_valid_i = 1'b0;
        inst_i = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;

        // x1 = 0x80000005 by forwarding, x2 = 3
        send(make_lui(20'h80000, 1), 0);
        send(make_i(3'd0, 1, 1, 12'h005), 0);
        send(make_i(3'd0, 2, 0, 12'h003), 1);
        // every register op in both operand orders, then SUB and SRA
        for (int f = 0; f < 8; f++) send(make_r(7'h00, f[2:0], 3 + f, 1, 2), 0);
        for (int f = 0; f < 8; f++) send(make_r(7'h00, f[2:0], 11 + f, 2, 1), 0);
        send(make_r(7'h20, 3'd0, 19, 1, 2), 0);
        send(make_r(7'h20, 3'd5, 20, 1, 2), 0);
        send(make_r(7'h20, 3'd5, 21, 2, 2), 1);
        // immediate forms, the unkept ones must vanish
        for (int f = 0; f < 8; f++) send(make_i(f[2:0], 22 + f, 1, 12'h8f0), 0);
        // two behind the producer through the register file
        send(make_i(3'd0, 4, 0, 12'h123), 1);
        send(make_r(7'h00, 3'd0, 5, 4, 4), 0);
        send(make_i(3'd0, 6, 0, 12'h007), 0);
        send(make_i(3'd0, 7, 0, 12'h001), 0);
        send(make_r(7'h00, 3'd0, 8, 6, 7), 2);
        // writes to x0
        send(make_i(3'd0, 0, 1, 12'h7ff), 0);
        send(make_r(7'h00, 3'd0, 9, 0, 0), 0);
        send(make_i(3'd0, 10, 0, 12'h001), 2);
        // load and MUL encodings are dropped
        send(32'h0000_2083, 0);
        send(make_r(7'h01, 3'd0, 11, 1, 2), 0);
        send(make_r(7'h00, 3'd0, 12, 11, 11), 3);

        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            s = $random(seed);
            case (s[4:0] % 18)
                0, 1, 2, 3, 4, 5, 6, 7:
                    inst_i = make_r(7'h00, s[2:0], r[2:0], r[5:3], r[8:6]);
                8, 9: inst_i = make_r(7'h20, {s[0], 1'b0, s[0]}, r[2:0], r[5:3], r[8:6]);
                10, 11, 12, 13, 14: inst_i = make_i(s[7:5], r[2:0], r[5:3], r[20:9]);
                15: inst_i = make_lui(s[31:12], r[2:0]);
                16: inst_i = make_i(3'd0, 0, r[5:3], r[20:9]);
                default: inst_i = {s[31:7], 7'b0000011};
            endcase
            send(inst_i, (r[27:26] == 2'b00) ? int'(r[25:24]) : 0);
        end
        repeat (4) @(posedge clk);

        if (u_dut.u_props.error_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "assertion failures were recorded");
        end
    end

endmodule

// File: alu_core_properties.sv
`include "core_config.svh"

module alu_core_properties (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst_valid_i,
    input  rv_isa_pkg::inst_word_t  inst_i,
    input  logic                    retire_valid_i,
    input  rv_pipe_pkg::retire_t    retire_i
);

    int unsigned          error_count = 0;
    logic [`XLEN-1:0]     shadow [`RF_DEPTH];
    logic [31:0]          model_raw;
    logic [`XLEN-1:0]     model_a;
    logic [`XLEN-1:0]     model_b;
    logic [`XLEN-1:0]     model_res;
    logic                 model_ok;
    // expected retirements, one slot per pipeline stage
    logic                 exp1_valid;
    logic                 exp2_valid;
    rv_pipe_pkg::retire_t exp1;
    rv_pipe_pkg::retire_t exp2;

    // --------------------
    // reference rules

    function automatic logic model_retires(input logic [31:0] raw);
        logic ok;
        case (raw[6:0])
            rv_isa_pkg::OPC_OP:
                ok = (raw[31:25] == 7'h00) ||
                     ((raw[31:25] == 7'h20) && ((raw[14:12] == 3'd0) || (raw[14:12] == 3'd5)));
            rv_isa_pkg::OPC_OP_IMM:
                ok = !(raw[14:12] inside {3'd1, 3'd3, 3'd5});
            rv_isa_pkg::OPC_LUI:
                ok = 1'b1;
            default:
                ok = 1'b0;
        endcase
        return ok;
    endfunction

    function automatic logic [`XLEN-1:0] model_result(input logic [31:0] raw,
                                                      input logic [`XLEN-1:0] a,
                                                      input logic [`XLEN-1:0] b_reg);
        logic [`XLEN-1:0]   b;
        logic [2*`XLEN-1:0] ext;
        logic [`XLEN-1:0]   res;
        logic [4:0]         sh;
        logic               is_op;
        is_op = (raw[6:0] == rv_isa_pkg::OPC_OP);
        b = is_op ? b_reg : {{(`XLEN-12){raw[31]}}, raw[31:20]};
        sh = b[4:0];
        // arithmetic shift through a sign-extended double word
        ext = {{`XLEN{a[`XLEN-1]}}, a} >> sh;
        case (raw[14:12])
            3'd0: res = (is_op && raw[30]) ? a - b : a + b;
            3'd1: res = a << sh;
            3'd2: res = ($signed(a) < $signed(b)) ? 1 : 0;
            3'd3: res = (a < b) ? 1 : 0;
            3'd4: res = a ^ b;
            3'd5: res = raw[30] ? ext[`XLEN-1:0] : a >> sh;
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        if (raw[6:0] == rv_isa_pkg::OPC_LUI) begin
            res = {raw[31:12], 12'h000};
        end
        return res;
    endfunction

    // --------------------
    // shadow model, updated in issue order

    always_comb begin
        model_raw = inst_i;
        model_a   = shadow[model_raw[19:15]];
        model_b   = shadow[model_raw[24:20]];
        model_ok  = model_retires(model_raw);
        model_res = model_result(model_raw, model_a, model_b);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RF_DEPTH; i++) begin
                shadow[i] <= '0;
            end
            exp1_valid <= 1'b0;
            exp2_valid <= 1'b0;
        end else begin
            exp1_valid  <= inst_valid_i && model_ok;
            exp1.rd     <= model_raw[11:7];
            exp1.result <= model_res;
            exp2_valid  <= exp1_valid;
            exp2        <= exp1;
            if (inst_valid_i && model_ok && (model_raw[11:7] != '0)) begin
                shadow[model_raw[11:7]] <= model_res;
            end
        end
    end

    // --------------------
    // checks

    a_reset_quiet: assert property (@(posedge clk) rst |=> !retire_valid_i)
        else begin
            $error("Error at %0t: retire_valid_o high after a reset edge", $time);
            error_count++;
        end

    a_retire_timing: assert property (@(posedge clk) disable iff (rst)
        retire_valid_i == exp2_valid)
        else begin
            $error("Error at %0t: retire_valid_o is %b, expected %b", $time,
                   retire_valid_i, exp2_valid);
            error_count++;
        end

    a_retire_value: assert property (@(posedge clk) disable iff (rst)
        retire_valid_i |-> (retire_i == exp2))
        else begin
            $error("Error at %0t: retired x%0d = %h, expected x%0d = %h", $time,
                   retire_i.rd, retire_i.result, exp2.rd, exp2.result);
            error_count++;
        end

endmodule

// File: alu_core.sv
`include "core_config.svh"

module alu_core (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst_valid_i,
    input  rv_isa_pkg::inst_word_t  inst_i,
    output logic                    retire_valid_o,
    output rv_pipe_pkg::retire_t    retire_o
);

    logic [`RF_ADDR_W-1:0] rs1_addr;
    logic [`RF_ADDR_W-1:0] rs2_addr;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;
    logic                  dec_valid;
    rv_pipe_pkg::dec_exe_t dec;

    // --------------------
    // decode

    inst_decoder u_dec (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .dec_valid_o  (dec_valid),
        .dec_o        (dec)
    );

    // write port fed by the retirement record
    reg_file u_rf (
        .clk        (clk),
        .rst        (rst),
        .rd1_addr_i (rs1_addr),
        .rd2_addr_i (rs2_addr),
        .rd1_data_o (rs1_data),
        .rd2_data_o (rs2_data),
        .wr_valid_i (retire_valid_o),
        .wr_i       (retire_o)
    );

    // --------------------
    // execute and writeback

    exec_stage u_exe (
        .clk            (clk),
        .rst            (rst),
        .dec_valid_i    (dec_valid),
        .dec_i          (dec),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o)
    );

endmodule

// File: exec_stage.sv
`include "core_config.svh"

module exec_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    dec_valid_i,
    input  rv_pipe_pkg::dec_exe_t   dec_i,
    output logic                    retire_valid_o,
    output rv_pipe_pkg::retire_t    retire_o
);

    logic                 fwd_a;
    logic                 fwd_b;
    logic                 wb_live;
    logic [`XLEN-1:0]     op_a;
    logic [`XLEN-1:0]     op_b;
    logic [4:0]           shamt;
    logic [`XLEN-1:0]     alu_res;
    rv_pipe_pkg::retire_t retire_d;

    // --------------------
    // operand forwarding

    // previous instruction sits in the retire register this cycle
    assign wb_live = retire_valid_o && (retire_o.rd != '0);

    assign fwd_a = wb_live && dec_i.rs1_used && (dec_i.rs1 == retire_o.rd);
    assign fwd_b = wb_live && dec_i.rs2_used && (dec_i.rs2 == retire_o.rd);

    assign op_a = fwd_a ? retire_o.result : dec_i.operand_a;
    assign op_b = fwd_b ? retire_o.result : dec_i.operand_b;

    // --------------------
    // alu

    // shift amount from low bits only
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec_i.alu_op)
            rv_pipe_pkg::ALU_ADD: begin
                alu_res = op_a + op_b;
            end
            rv_pipe_pkg::ALU_SUB: begin
                alu_res = op_a - op_b;
            end
            rv_pipe_pkg::ALU_AND: begin
                alu_res = op_a & op_b;
            end
            rv_pipe_pkg::ALU_OR: begin
                alu_res = op_a | op_b;
            end
            rv_pipe_pkg::ALU_XOR: begin
                alu_res = op_a ^ op_b;
            end
            rv_pipe_pkg::ALU_SLT: begin
                alu_res = {{(`XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            rv_pipe_pkg::ALU_SLTU: begin
                alu_res = {{(`XLEN-1){1'b0}}, (op_a < op_b)};
            end
            rv_pipe_pkg::ALU_SLL: begin
                alu_res = op_a << shamt;
            end
            rv_pipe_pkg::ALU_SRL: begin
                alu_res = op_a >> shamt;
            end
            rv_pipe_pkg::ALU_SRA: begin
                // sign bit fills from the left
                alu_res = $unsigned($signed(op_a) >>> shamt);
            end
            default: begin
                alu_res = '0;
            end
        endcase
    end

    // --------------------
    // execute/writeback register

    assign retire_d.rd     = dec_i.rd;
    assign retire_d.result = alu_res;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= dec_valid_i;
        end
    end

    // record held between retirements
    always_ff @(posedge clk) begin
        if (dec_valid_i) begin
            retire_o <= retire_d;
        end
    end

endmodule

// File: reg_file.sv
`include "core_config.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`RF_ADDR_W-1:0]   rd1_addr_i,
    input  logic [`RF_ADDR_W-1:0]   rd2_addr_i,
    output logic [`XLEN-1:0]        rd1_data_o,
    output logic [`XLEN-1:0]        rd2_data_o,
    input  logic                    wr_valid_i,
    input  rv_pipe_pkg::retire_t    wr_i
);

    logic [`XLEN-1:0] regs [`RF_DEPTH];
    logic             wr_en;

    // x0 is never written
    assign wr_en = wr_valid_i && (wr_i.rd != '0);

    // --------------------
    // write port

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_i.rd] <= wr_i.result;
        end
    end

    // --------------------
    // read ports, write-first

    function automatic logic [`XLEN-1:0] read_port(input logic [`RF_ADDR_W-1:0] addr);
        logic [`XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en && (wr_i.rd == addr)) begin
            data = wr_i.result;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rd1_data_o = read_port(rd1_addr_i);
        rd2_data_o = read_port(rd2_addr_i);
    end

endmodule

// File: inst_decoder.sv
`include "core_config.svh"

module inst_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    inst_valid_i,
    input  rv_isa_pkg::inst_word_t  inst_i,
    output logic [`RF_ADDR_W-1:0]   rs1_addr_o,
    output logic [`RF_ADDR_W-1:0]   rs2_addr_o,
    input  logic [`XLEN-1:0]        rs1_data_i,
    input  logic [`XLEN-1:0]        rs2_data_i,
    output logic                    dec_valid_o,
    output rv_pipe_pkg::dec_exe_t   dec_o
);

    rv_pipe_pkg::alu_op_t  alu_op_d;
    rv_pipe_pkg::dec_exe_t dec_d;
    logic                  supported_d;
    logic                  rs1_used_d;
    logic                  rs2_used_d;
    logic                  is_lui;
    logic                  funct7_alt;
    logic                  r_legal;
    logic [`XLEN-1:0]      imm_i;
    logic [`XLEN-1:0]      imm_u;

    // --------------------
    // field decode

    assign funct7_alt = (inst_i.r.funct7 == rv_isa_pkg::F7_ALT);

    // alt funct7 only exists for SUB and SRA
    assign r_legal = (inst_i.r.funct7 == rv_isa_pkg::F7_BASE) ||
                     (funct7_alt && ((inst_i.r.funct3 == rv_isa_pkg::F3_ADD_SUB) ||
                                     (inst_i.r.funct3 == rv_isa_pkg::F3_SRL_SRA)));

    always_comb begin
        alu_op_d    = rv_pipe_pkg::ALU_ADD;
        supported_d = 1'b0;
        rs1_used_d  = 1'b0;
        rs2_used_d  = 1'b0;
        is_lui      = 1'b0;
        case (inst_i.r.opcode)
            rv_isa_pkg::OPC_OP: begin
                supported_d = r_legal;
                rs1_used_d  = 1'b1;
                rs2_used_d  = 1'b1;
                case (inst_i.r.funct3)
                    rv_isa_pkg::F3_ADD_SUB:
                        alu_op_d = funct7_alt ? rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
                    rv_isa_pkg::F3_SRL_SRA:
                        alu_op_d = funct7_alt ? rv_pipe_pkg::ALU_SRA : rv_pipe_pkg::ALU_SRL;
                    rv_isa_pkg::F3_SLL:  alu_op_d = rv_pipe_pkg::ALU_SLL;
                    rv_isa_pkg::F3_SLT:  alu_op_d = rv_pipe_pkg::ALU_SLT;
                    rv_isa_pkg::F3_SLTU: alu_op_d = rv_pipe_pkg::ALU_SLTU;
                    rv_isa_pkg::F3_XOR:  alu_op_d = rv_pipe_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:   alu_op_d = rv_pipe_pkg::ALU_OR;
                    default:             alu_op_d = rv_pipe_pkg::ALU_AND;
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                rs1_used_d  = 1'b1;
                supported_d = 1'b1;
                // immediate shifts and SLTIU are not kept
                case (inst_i.i.funct3)
                    rv_isa_pkg::F3_ADD_SUB: alu_op_d = rv_pipe_pkg::ALU_ADD;
                    rv_isa_pkg::F3_SLT:     alu_op_d = rv_pipe_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR:     alu_op_d = rv_pipe_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:      alu_op_d = rv_pipe_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND:     alu_op_d = rv_pipe_pkg::ALU_AND;
                    default:                supported_d = 1'b0;
                endcase
            end
            rv_isa_pkg::OPC_LUI: begin
                supported_d = 1'b1;
                is_lui      = 1'b1;
            end
            default: supported_d = 1'b0;
        endcase
    end

    // unused sources read x0
    assign rs1_addr_o = rs1_used_d ? inst_i.r.rs1 : '0;
    assign rs2_addr_o = rs2_used_d ? inst_i.r.rs2 : '0;

    // --------------------
    // immediates and operands

    assign imm_i = {{(`XLEN-12){inst_i.i.imm[11]}}, inst_i.i.imm};
    assign imm_u = {inst_i.i.imm, inst_i.i.rs1, inst_i.i.funct3, {12{1'b0}}};

    always_comb begin
        dec_d.alu_op    = alu_op_d;
        dec_d.rd        = inst_i.r.rd;
        // raw source fields, the used flags qualify them
        dec_d.rs1       = inst_i.r.rs1;
        dec_d.rs2       = inst_i.r.rs2;
        dec_d.rs1_used  = rs1_used_d;
        dec_d.rs2_used  = rs2_used_d;
        // LUI computes 0 + upper immediate
        dec_d.operand_a = is_lui ? '0 : rs1_data_i;
        if (is_lui) begin
            dec_d.operand_b = imm_u;
        end else if (rs2_used_d) begin
            dec_d.operand_b = rs2_data_i;
        end else begin
            dec_d.operand_b = imm_i;
        end
    end

    // --------------------
    // decode/execute register

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_o <= 1'b0;
        end else begin
            dec_valid_o <= inst_valid_i && supported_d;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            dec_o <= dec_d;
        end
    end

endmodule

// File: rv_pipe_pkg.sv
`include "core_config.svh"

package rv_pipe_pkg;

    // --------------------
    // alu operations

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_t;

    // --------------------
    // stage bundles

    // decode to execute
    typedef struct packed {
        alu_op_t               alu_op;
        logic [`RF_ADDR_W-1:0] rd;
        logic [`RF_ADDR_W-1:0] rs1;
        logic [`RF_ADDR_W-1:0] rs2;
        // source actually read, gates forwarding
        logic                  rs1_used;
        logic                  rs2_used;
        logic [`XLEN-1:0]      operand_a;
        logic [`XLEN-1:0]      operand_b;
    } dec_exe_t;

    // retirement record, also the register file write port
    typedef struct packed {
        logic [`RF_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]      result;
    } retire_t;

endpackage

// File: rv_isa_pkg.sv
`include "core_config.svh"

package rv_isa_pkg;

    // --------------------
    // major opcodes kept by this core

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_t;

    // funct3 encodings of the integer ops
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_t;

    // funct7 values for register-register ops
    localparam logic [6:0] F7_BASE = 7'b0000000;
    // selects SUB and SRA
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // --------------------
    // instruction word views

    // register-register layout
    typedef struct packed {
        logic [6:0]            funct7;
        logic [`RF_ADDR_W-1:0] rs2;
        logic [`RF_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [`RF_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } r_fields_t;

    // immediate layout, LUI takes bits 31:12 from imm, rs1 and funct3
    typedef struct packed {
        logic [11:0]           imm;
        logic [`RF_ADDR_W-1:0] rs1;
        funct3_t               funct3;
        logic [`RF_ADDR_W-1:0] rd;
        opcode_t               opcode;
    } i_fields_t;

    // one 32-bit word, decoded by opcode
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_word_t;

endpackage

// File: core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// --------------------
// datapath sizing

// integer datapath width
`define XLEN 32

// architectural register count
`define RF_DEPTH 32

// bits needed to index the register file
`define RF_ADDR_W 5

`endif
